// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_exec_tb
FILELIST  = cpu_exec.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_exec.f ====
hdl/cpu_exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_ctrl.sv
hdl/bank_regs.sv
hdl/cpu_exec.sv
test/cpu_exec_assertions.sv
test/cpu_exec_tb.sv

// ==== hdl/bank_regs.sv ====
//####################
// banked register file
// four banks of XWA/XBC/XDE/XHL plus XIX/XIY/XIZ/XSP
// sized reads and writes, exchange, steps
// stack adjust, bank pointer, dump port
//####################
`timescale 1ns/1ps

module bank_regs import cpu_exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_ctl_t    ctl,
    input  logic [7:0]  src_code,
    input  logic [7:0]  dst_code,
    input  logic [31:0] wr_data,
    output logic [31:0] src_data,
    output logic [31:0] dst_data,
    input  logic [15:0] sr,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout
);

    // 00-3F bank bytes, 40-4F pointer bytes
    logic [7:0]  regs [0:REG_BYTES-1];
    logic [1:0]  rfp;
    // {hit, byte index}
    logic [7:0]  src_loc;
    logic [7:0]  dst_loc;
    logic [6:0]  src_idx;
    logic [6:0]  dst_idx;
    logic [6:0]  step_idx;
    logic [2:0]  nbytes;
    logic [31:0] step_old;
    logic [31:0] step_new;
    logic [31:0] xsp;
    logic [31:0] xsp_new;

    // map a register code onto the flat byte array
    function automatic logic [7:0] locate(input logic [7:0] code, input logic [1:0] bank);
        logic [1:0] prev;
        prev = bank - 2'd1;
        case (code[7:4])
            CUR_BANK:  locate = {2'b10, bank, code[3:0]};
            PREV_BANK: locate = {2'b10, prev, code[3:0]};
            PTR_SPACE: locate = {4'b1100, code[3:0]};
            // only 00-3F are absolute, the rest miss
            default:   locate = {code[7:6] == 2'b00, 1'b0, code[5:0]};
        endcase
    endfunction

    function automatic logic [6:0] align(input logic [6:0] idx, input op_size_e sz);
        case (sz)
            SZ_BYTE: align = idx;
            SZ_WORD: align = {idx[6:1], 1'b0};
            default: align = {idx[6:2], 2'b00};
        endcase
    endfunction

    assign nbytes   = size_bytes(ctl.size);
    assign src_loc  = locate(src_code, rfp);
    assign dst_loc  = locate(dst_code, rfp);
    assign src_idx  = align(src_loc[6:0], ctl.size);
    assign dst_idx  = align(dst_loc[6:0], ctl.size);
    assign step_idx = {src_loc[6:2], 2'b00};

    // sized reads, zero extended
    always_comb begin
        src_data = 32'd0;
        dst_data = 32'd0;
        for (int i = 0; i < 4; i++) begin
            if (3'(i) < nbytes) begin
                if (src_loc[7]) begin
                    src_data[8*i +: 8] = regs[src_idx | 7'(i)];
                end
                if (dst_loc[7]) begin
                    dst_data[8*i +: 8] = regs[dst_idx | 7'(i)];
                end
            end
        end
    end

    // steps work on the whole 32-bit register
    assign step_old = {regs[step_idx | 7'd3], regs[step_idx | 7'd2],
                       regs[step_idx | 7'd1], regs[step_idx]};
    assign step_new = ctl.step_dec ? step_old - 32'(nbytes) : step_old + 32'(nbytes);

    assign xsp     = {regs[XSP_IDX | 7'd3], regs[XSP_IDX | 7'd2],
                      regs[XSP_IDX | 7'd1], regs[XSP_IDX]};
    assign xsp_new = ctl.sp_sub ? xsp - {16'd0, ctl.sp_amt} : xsp + {16'd0, ctl.sp_amt};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_BYTES; i++) begin
                regs[i] <= 8'd0;
            end
            for (int i = 0; i < 4; i++) begin
                regs[XSP_IDX | 7'(i)] <= XSP_RESET[8*i +: 8];
            end
        end else begin
            if (ctl.wr_en && dst_loc[7]) begin
                for (int i = 0; i < 4; i++) begin
                    if (3'(i) < nbytes) begin
                        regs[dst_idx | 7'(i)] <= wr_data[8*i +: 8];
                    end
                end
            end
            // exchange puts the old destination into the source
            if (ctl.ex_en && src_loc[7]) begin
                for (int i = 0; i < 4; i++) begin
                    if (3'(i) < nbytes) begin
                        regs[src_idx | 7'(i)] <= dst_data[8*i +: 8];
                    end
                end
            end
            if ((ctl.step_inc || ctl.step_dec) && src_loc[7]) begin
                for (int i = 0; i < 4; i++) begin
                    regs[step_idx | 7'(i)] <= step_new[8*i +: 8];
                end
            end
            if (ctl.sp_add || ctl.sp_sub) begin
                for (int i = 0; i < 4; i++) begin
                    regs[XSP_IDX | 7'(i)] <= xsp_new[8*i +: 8];
                end
            end
        end
    end

    // bank pointer, wraps in both directions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else begin
            case (ctl.bank_op)
                BNK_INC: rfp <= rfp + 2'd1;
                BNK_DEC: rfp <= rfp - 2'd1;
                BNK_SET: rfp <= ctl.bank_imm;
                default: rfp <= rfp;
            endcase
        end
    end

    // dump read, one cycle latency
    always_ff @(posedge clk) begin
        if (dmp_addr < DMP_SR_HI) begin
            dmp_dout <= regs[dmp_addr[6:0]];
        end else if (dmp_addr == DMP_SR_HI) begin
            dmp_dout <= sr[15:8];
        end else if (dmp_addr == DMP_SR_LO) begin
            dmp_dout <= sr[7:0];
        end else begin
            dmp_dout <= 8'd0;
        end
    end

endmodule

// ==== hdl/cpu_exec.sv ====
//####################
// execution core top level
// controller, ALU and register file
//####################
`timescale 1ns/1ps

module cpu_exec import cpu_exec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_valid,
    input  exec_cmd_t  cmd,
    output logic       busy,
    output logic       done,
    output flags_t     flags,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_dout
);

    alu_op_e     alu_op;
    op_size_e    size;
    logic [7:0]  src_code;
    logic [7:0]  dst_code;
    logic [31:0] imm;
    reg_ctl_t    ctl;
    flags_t      alu_flags;
    logic [15:0] sr;
    logic [31:0] src_data;
    logic [31:0] dst_data;
    logic [31:0] alu_b;
    logic [31:0] result;

    // immediate is zero unless LDI, whose source reads zero
    assign alu_b = src_data | imm;

    exec_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .alu_op    (alu_op),
        .size      (size),
        .src_code  (src_code),
        .dst_code  (dst_code),
        .imm       (imm),
        .ctl       (ctl),
        .alu_flags (alu_flags),
        .flags     (flags),
        .sr        (sr)
    );

    exec_alu u_alu (
        .alu_op (alu_op),
        .size   (size),
        .a      (dst_data),
        .b      (alu_b),
        .result (result),
        .flags  (alu_flags)
    );

    bank_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .ctl      (ctl),
        .src_code (src_code),
        .dst_code (dst_code),
        .wr_data  (result),
        .src_data (src_data),
        .dst_data (dst_data),
        .sr       (sr),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout)
    );

endmodule

// ==== hdl/cpu_exec_pkg.sv ====
//####################
// shared definitions for the execution core
// operation, size, ALU and bank-pointer enums
// command, register control and flag structs
// register-code and dump address constants
//####################
package cpu_exec_pkg;

    typedef enum logic [3:0] {
        OP_MOV,
        OP_LDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_EX,
        OP_STEP_INC,
        OP_STEP_DEC,
        OP_SP_ADD,
        OP_SP_SUB,
        OP_BANK_INC,
        OP_BANK_DEC,
        OP_BANK_SET
    } exec_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_LONG
    } op_size_e;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        BNK_NONE,
        BNK_INC,
        BNK_DEC,
        BNK_SET
    } bank_op_e;

    typedef struct packed {
        exec_op_e    op;
        op_size_e    size;
        logic [7:0]  src;
        logic [7:0]  dst;
        logic [31:0] imm;
    } exec_cmd_t;

    typedef struct packed {
        logic        wr_en;
        op_size_e    size;
        logic        ex_en;
        logic        step_inc;
        logic        step_dec;
        logic        sp_add;
        logic        sp_sub;
        logic [15:0] sp_amt;
        bank_op_e    bank_op;
        logic [1:0]  bank_imm;
    } reg_ctl_t;

    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

    // upper nibble of a register code
    localparam logic [3:0] CUR_BANK  = 4'he;
    localparam logic [3:0] PREV_BANK = 4'hd;
    localparam logic [3:0] PTR_SPACE = 4'hf;

    // unmapped code, reads as zero
    localparam logic [7:0] NULL_CODE = 8'h40;

    // 64 bank bytes then XIX, XIY, XIZ, XSP
    localparam int         REG_BYTES = 80;
    localparam logic [6:0] XSP_IDX   = 7'd76;
    localparam logic [31:0] XSP_RESET = 32'h100;

    localparam logic [7:0] DMP_SR_HI = 8'h50;
    localparam logic [7:0] DMP_SR_LO = 8'h51;

    // bytes moved by one operand, also the step amount
    function automatic logic [2:0] size_bytes(input op_size_e sz);
        case (sz)
            SZ_BYTE: size_bytes = 3'd1;
            SZ_WORD: size_bytes = 3'd2;
            default: size_bytes = 3'd4;
        endcase
    endfunction

endpackage

// ==== hdl/exec_alu.sv ====
//####################
// sized ALU for the execution core
// pass, add, subtract, and, xor
// zero and carry at operand size
//####################
`timescale 1ns/1ps

module exec_alu import cpu_exec_pkg::*; (
    input  alu_op_e     alu_op,
    input  op_size_e    size,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output flags_t      flags
);

    logic [31:0] mask;
    logic [31:0] am;
    logic [31:0] bm;
    logic [32:0] sum;
    logic [32:0] diff;
    logic        cy;

    // carry or borrow sits just above the top bit of the size
    function automatic logic size_carry(input logic [32:0] raw, input op_size_e sz);
        case (sz)
            SZ_BYTE: size_carry = raw[8];
            SZ_WORD: size_carry = raw[16];
            default: size_carry = raw[32];
        endcase
    endfunction

    always_comb begin
        case (size)
            SZ_BYTE: mask = 32'h0000_00ff;
            SZ_WORD: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
    end

    assign am   = a & mask;
    assign bm   = b & mask;
    assign sum  = {1'b0, am} + {1'b0, bm};
    // masked operands make the borrow propagate to the size boundary
    assign diff = {1'b0, am} - {1'b0, bm};

    always_comb begin
        result = bm;
        cy     = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                result = sum[31:0] & mask;
                cy     = size_carry(sum, size);
            end
            ALU_SUB: begin
                result = diff[31:0] & mask;
                cy     = size_carry(diff, size);
            end
            ALU_AND: result = am & bm;
            ALU_XOR: result = am ^ bm;
            default: result = bm;
        endcase
    end

    assign flags = '{zero: (result == 32'd0), carry: cy};

endmodule

// ==== hdl/exec_ctrl.sv ====
//####################
// command capture and decode
// register-file controls, flag register
// busy, done and status word
//####################
`timescale 1ns/1ps

module exec_ctrl import cpu_exec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  exec_cmd_t   cmd,
    output logic        busy,
    output logic        done,
    output alu_op_e     alu_op,
    output op_size_e    size,
    output logic [7:0]  src_code,
    output logic [7:0]  dst_code,
    output logic [31:0] imm,
    output reg_ctl_t    ctl,
    input  flags_t      alu_flags,
    output flags_t      flags,
    output logic [15:0] sr
);

    exec_cmd_t cmd_q;
    logic      accept;
    logic      flag_we;

    assign accept = cmd_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            flags <= '0;
        end else begin
            busy <= accept;
            if (flag_we) begin
                flags <= alu_flags;
            end
        end
    end

    // execute lasts one cycle, so done matches busy
    assign done = busy;

    always_comb begin
        ctl      = '0;
        alu_op   = ALU_PASS_B;
        src_code = cmd_q.src;
        imm      = 32'd0;
        flag_we  = 1'b0;
        if (busy) begin
            ctl.size = cmd_q.size;
            case (cmd_q.op)
                OP_MOV: ctl.wr_en = 1'b1;
                OP_LDI: begin
                    // source reads zero, immediate carries the value
                    ctl.wr_en = 1'b1;
                    src_code  = NULL_CODE;
                    imm       = cmd_q.imm;
                end
                OP_ADD: begin
                    ctl.wr_en = 1'b1;
                    alu_op    = ALU_ADD;
                    flag_we   = 1'b1;
                end
                OP_SUB: begin
                    ctl.wr_en = 1'b1;
                    alu_op    = ALU_SUB;
                    flag_we   = 1'b1;
                end
                OP_AND: begin
                    ctl.wr_en = 1'b1;
                    alu_op    = ALU_AND;
                    flag_we   = 1'b1;
                end
                OP_XOR: begin
                    ctl.wr_en = 1'b1;
                    alu_op    = ALU_XOR;
                    flag_we   = 1'b1;
                end
                OP_EX: begin
                    ctl.wr_en = 1'b1;
                    ctl.ex_en = 1'b1;
                end
                OP_STEP_INC: ctl.step_inc = 1'b1;
                OP_STEP_DEC: ctl.step_dec = 1'b1;
                OP_SP_ADD: begin
                    ctl.sp_add = 1'b1;
                    ctl.sp_amt = cmd_q.imm[15:0];
                end
                OP_SP_SUB: begin
                    ctl.sp_sub = 1'b1;
                    ctl.sp_amt = cmd_q.imm[15:0];
                end
                OP_BANK_INC: ctl.bank_op = BNK_INC;
                OP_BANK_DEC: ctl.bank_op = BNK_DEC;
                OP_BANK_SET: begin
                    ctl.bank_op  = BNK_SET;
                    ctl.bank_imm = cmd_q.imm[1:0];
                end
                default: ctl.wr_en = 1'b0;
            endcase
        end
    end

    assign size     = ctl.size;
    assign dst_code = cmd_q.dst;

    // carry in bit 0, zero in bit 6
    assign sr = {9'd0, flags.zero, 5'd0, flags.carry};

endmodule

// ==== test/cpu_exec_assertions.sv ====
//####################
// bound checks for the execution core
// done/busy timing after a strobe
// stack pointer value during reset
//####################
`timescale 1ns/1ps

module cpu_exec_assertions import cpu_exec_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        cmd_valid,
    input logic        busy,
    input logic        done,
    input logic [31:0] xsp
);

    // failed checks so far
    int fail_count = 0;

    // an accepted strobe opens the execute cycle at the next edge
    assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && !busy) |=> (busy && done))
        else begin
            fail_count++;
            $error("accepted strobe did not raise busy and done");
        end

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    // no execute cycle without an accepted strobe
    assert property (@(posedge clk) disable iff (rst)
        !(cmd_valid && !busy) |=> !busy)
        else begin
            fail_count++;
            $error("busy rose without an accepted strobe");
        end

    assert property (@(posedge clk) rst |=> (xsp == XSP_RESET))
        else begin
            fail_count++;
            $error("stack pointer not at its reset value");
        end

endmodule

// ==== test/cpu_exec_tb.sv ====
//####################
// testbench for the execution core
// clock, reset, directed and random commands
// byte-level reference model of the register file
// dump and flag compare, cycle limit
//####################
`timescale 1ns/1ps

module cpu_exec_tb
    import cpu_exec_pkg::*;
();

    localparam int         N_CMDS     = 300;
    localparam int         DUMP_EVERY = 20;
    localparam logic [7:0] DUMP_LAST  = 8'h57;
    // 300 x 3 command cycles, 17 dumps of 89 cycles, reset and margin
    localparam int         MAX_CYCLES = 4000;

    logic       clk;
    logic       rst;
    logic       cmd_valid;
    exec_cmd_t  cmd;
    logic       busy;
    logic       done;
    flags_t     flags;
    logic [7:0] dmp_addr;
    logic [7:0] dmp_dout;

    // reference state
    logic [7:0]  m_regs [0:79];
    logic [1:0]  m_bank;
    flags_t      m_flags;
    logic [31:0] lcg_state;
    int          reg_errs;
    int          flag_errs;
    int          seq_errs;
    int          cycles;

    cpu_exec DUT (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .flags     (flags),
        .dmp_addr  (dmp_addr),
        .dmp_dout  (dmp_dout)
    );

    bind cpu_exec cpu_exec_assertions u_checks (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .done      (done),
        .xsp       ({u_regs.regs[79], u_regs.regs[78], u_regs.regs[77], u_regs.regs[76]})
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int byte_count(input op_size_e sz);
        if (sz == SZ_BYTE) return 1;
        if (sz == SZ_WORD) return 2;
        return 4;
    endfunction

    // byte offset of a register code, -1 when the code maps nowhere
    function automatic int code_index(input logic [7:0] code, input logic [1:0] bank);
        int low;
        low = int'(code[3:0]);
        if (code[7:4] == 4'he) return 16 * int'(bank) + low;
        if (code[7:4] == 4'hd) return 16 * ((int'(bank) + 3) % 4) + low;
        if (code[7:4] == 4'hf) return 64 + low;
        if (code < 8'h40) return int'(code);
        return -1;
    endfunction

    function automatic logic [31:0] read_bytes(input int idx, input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            if (idx >= 0) v[8*i +: 8] = m_regs[idx + i];
        end
        return v;
    endfunction

    task automatic write_bytes(input int idx, input int n, input logic [31:0] v);
        for (int i = 0; i < n; i++) begin
            if (idx >= 0) m_regs[idx + i] = v[8*i +: 8];
        end
    endtask

    // expected ALU result, carry as overflow past or borrow below the size
    function automatic logic [31:0] alu_ref(input exec_op_e op, input op_size_e sz,
                                            input logic [31:0] a, input logic [31:0] b,
                                            output flags_t f);
        logic [31:0] mask;
        logic [63:0] am;
        logic [63:0] bm;
        logic [31:0] res;
        mask = (sz == SZ_BYTE) ? 32'h0000_00ff : (sz == SZ_WORD) ? 32'h0000_ffff : 32'hffff_ffff;
        am = {32'd0, a & mask};
        bm = {32'd0, b & mask};
        f = '0;
        case (op)
            OP_ADD: begin
                res = 32'(am + bm) & mask;
                f.carry = (am + bm) > {32'd0, mask};
            end
            OP_SUB: begin
                res = 32'(am - bm) & mask;
                f.carry = am < bm;
            end
            OP_AND: res = a & b & mask;
            OP_XOR: res = (a ^ b) & mask;
            default: res = b & mask;
        endcase
        f.zero = (res == 32'd0);
        return res;
    endfunction

    task automatic model_apply(input exec_cmd_t c);
        int          n;
        int          si;
        int          di;
        int          base;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        flags_t      f;
        n    = byte_count(c.size);
        si   = code_index(c.src, m_bank);
        di   = code_index(c.dst, m_bank);
        base = si - (si % 4);
        a    = read_bytes(di, n);
        b    = read_bytes(si, n);
        case (c.op)
            OP_MOV: write_bytes(di, n, b);
            OP_LDI: write_bytes(di, n, c.imm);
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                r = alu_ref(c.op, c.size, a, b, f);
                write_bytes(di, n, r);
                m_flags = f;
            end
            OP_EX: begin
                write_bytes(di, n, b);
                write_bytes(si, n, a);
            end
            OP_STEP_INC: write_bytes(base, 4, read_bytes(base, 4) + 32'(n));
            OP_STEP_DEC: write_bytes(base, 4, read_bytes(base, 4) - 32'(n));
            OP_SP_ADD: write_bytes(76, 4, read_bytes(76, 4) + {16'd0, c.imm[15:0]});
            OP_SP_SUB: write_bytes(76, 4, read_bytes(76, 4) - {16'd0, c.imm[15:0]});
            OP_BANK_INC: m_bank = m_bank + 2'd1;
            OP_BANK_DEC: m_bank = m_bank - 2'd1;
            OP_BANK_SET: m_bank = c.imm[1:0];
            default: m_bank = m_bank;
        endcase
    endtask

    function automatic logic [7:0] dump_expect(input logic [7:0] addr);
        if (addr < 8'h50) return m_regs[addr[6:0]];
        if (addr == DMP_SR_LO) return {1'b0, m_flags.zero, 5'd0, m_flags.carry};
        return 8'h00;
    endfunction

    function automatic exec_cmd_t make_cmd(input exec_op_e op, input op_size_e sz,
                                           input logic [7:0] src, input logic [7:0] dst,
                                           input logic [31:0] imm);
        exec_cmd_t c;
        c.op   = op;
        c.size = sz;
        c.src  = src;
        c.dst  = dst;
        c.imm  = imm;
        return c;
    endfunction

    // legal code from one of the four spaces, aligned to the size
    function automatic logic [7:0] random_code(input op_size_e sz);
        logic [31:0] r;
        logic [7:0]  code;
        r = next_rand();
        case (r[31:30])
            2'd0: code = {2'b00, r[21:16]};
            2'd1: code = {4'hd, r[19:16]};
            2'd2: code = {4'he, r[19:16]};
            default: code = {4'hf, r[19:16]};
        endcase
        if (sz == SZ_WORD) code[0] = 1'b0;
        if (sz == SZ_LONG) code[1:0] = 2'b00;
        return code;
    endfunction

    function automatic exec_cmd_t random_cmd();
        logic [31:0] r;
        op_size_e    sz;
        r  = next_rand();
        sz = op_size_e'(2'(r[15:8] % 3));
        return make_cmd(exec_op_e'(4'(r[31:16] % 14)), sz, random_code(sz),
                        random_code(sz), next_rand());
    endfunction

    task automatic check_reg_byte(input logic [7:0] addr, input logic [7:0] got,
                                  input logic [7:0] exp);
        if (got !== exp) begin
            reg_errs++;
            $display("Fail dmp_dout at dmp_addr 0x%02h: got 0x%02h, expected 0x%02h",
                     addr, got, exp);
        end
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail flags: got 0x%01h, expected 0x%01h", got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            seq_errs++;
            $display("Fail busy: got 0x%01h, expected 0x%01h", got, exp);
        end
    endtask

    // one accepted command, optionally a second strobe while busy
    task automatic send_cmd(input exec_cmd_t c, input bit stray);
        int waited;
        @(negedge clk);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        waited    = 0;
        while (!done && waited < 6) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            seq_errs++;
            $display("done never rose after a %s command", c.op.name());
        end else if (waited != 0) begin
            seq_errs++;
            $display("done rose %0d cycles late after a %s command", waited, c.op.name());
        end
        check_busy(busy, 1'b1);
        model_apply(c);
        if (stray) begin
            cmd       = make_cmd(OP_LDI, SZ_LONG, 8'hf0, 8'he0, 32'h5a5a_a5a5);
            cmd_valid = 1'b1;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        if (done) begin
            seq_errs++;
            $display("done stayed high for more than one cycle");
        end
        check_busy(busy, 1'b0);
        check_flags(flags, m_flags);
    endtask

    // dump reads are pipelined one address per cycle
    task automatic full_dump();
        for (int a = 0; a <= int'(DUMP_LAST); a++) begin
            @(negedge clk);
            if (a > 0) check_reg_byte(8'(a - 1), dmp_dout, dump_expect(8'(a - 1)));
            dmp_addr = 8'(a);
        end
        @(negedge clk);
        check_reg_byte(DUMP_LAST, dmp_dout, dump_expect(DUMP_LAST));
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        dmp_addr  = 8'd0;
        lcg_state = 32'hfe1285b0;
        reg_errs  = 0;
        flag_errs = 0;
        seq_errs  = 0;
        cycles    = 0;
        m_bank    = 2'd0;
        m_flags   = '0;
        for (int i = 0; i < 80; i++) m_regs[i] = 8'd0;
        write_bytes(76, 4, XSP_RESET);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        full_dump();
        check_flags(flags, '0);

        // bank wrap, previous bank, steps and stack adjust
        send_cmd(make_cmd(OP_BANK_DEC, SZ_BYTE, 8'he0, 8'he0, 32'd0), 1'b0);
        send_cmd(make_cmd(OP_LDI, SZ_LONG, 8'he0, 8'he4, 32'h1234_5678), 1'b1);
        send_cmd(make_cmd(OP_BANK_INC, SZ_BYTE, 8'he0, 8'he0, 32'd0), 1'b0);
        send_cmd(make_cmd(OP_MOV, SZ_LONG, 8'hd4, 8'he8, 32'd0), 1'b0);
        send_cmd(make_cmd(OP_BANK_SET, SZ_BYTE, 8'he0, 8'he0, 32'd2), 1'b0);
        send_cmd(make_cmd(OP_STEP_INC, SZ_WORD, 8'hf0, 8'hf0, 32'd0), 1'b0);
        send_cmd(make_cmd(OP_STEP_DEC, SZ_LONG, 8'hfc, 8'hfc, 32'd0), 1'b1);
        send_cmd(make_cmd(OP_STEP_DEC, SZ_BYTE, 8'he4, 8'he4, 32'd0), 1'b0);
        send_cmd(make_cmd(OP_SP_ADD, SZ_WORD, 8'hfc, 8'hfc, 32'hffff_0010), 1'b0);
        send_cmd(make_cmd(OP_SP_SUB, SZ_WORD, 8'hfc, 8'hfc, 32'h0000_0003), 1'b0);
        full_dump();

        for (int i = 0; i < N_CMDS; i++) begin
            send_cmd(random_cmd(), (i % 4) == 3);
            if ((i % DUMP_EVERY) == DUMP_EVERY - 1) full_dump();
        end

        $display("errors: %0d register, %0d flag, %0d timing, %0d assertion",
                 reg_errs, flag_errs, seq_errs, DUT.u_checks.fail_count);
        if (reg_errs + flag_errs + seq_errs + DUT.u_checks.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
